//--- hw/noc_in_port.sv
/*
 * NoC router input port
 * Buffers incoming flits in a small circular FIFO and computes the
 * XY output direction of the head flit against the node coordinate.
 */

`timescale 1ns/10ps

module noc_in_port #(
  parameter noc_pkg::noc_dir_e in_dir = noc_pkg::DirLocal
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  noc_pkg::noc_coord_t id_i,
  input  logic               valid_i,
  input  noc_pkg::noc_flit_t flit_i,
  output logic               ready_o,
  input  logic               pop_i,
  output logic               head_valid_o,
  output noc_pkg::noc_flit_t head_flit_o,
  output noc_pkg::noc_dir_e  route_o
);

  import noc_pkg::*;

  noc_flit_t           mem_q [InFifoDepth];
  logic [FifoPtrW-1:0] wr_ptr_q;
  logic [FifoPtrW-1:0] rd_ptr_q;
  logic [FifoCntW-1:0] count_q;
  logic                push;
  logic                pop;

  function automatic logic [FifoPtrW-1:0] ptr_inc(input logic [FifoPtrW-1:0] ptr);
    if (ptr == FifoPtrW'(InFifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o      = (count_q != FifoCntW'(InFifoDepth));
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];
  assign push         = valid_i && ready_o;
  // The allocator only grants a valid head
  assign pop          = pop_i;

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Dimension-ordered routing with x resolved before y
  always_comb begin
    if (head_flit_o.dst.x > id_i.x) begin
      route_o = DirEast;
    end else if (head_flit_o.dst.x < id_i.x) begin
      route_o = DirWest;
    end else if (head_flit_o.dst.y > id_i.y) begin
      route_o = DirNorth;
    end else if (head_flit_o.dst.y < id_i.y) begin
      route_o = DirSouth;
    end else begin
      route_o = DirLocal;
    end
  end

  // A pop needs a flit at the head
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop |-> head_valid_o)
    else $error("input FIFO popped while empty");

  // Neighbors never send a flit that would turn back
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    head_valid_o |-> (route_o != in_dir))
    else $error("loopback route on input %0d", in_dir);

endmodule

//--- hw/noc_nw_router.sv
/*
 * Network router node
 * One request router and one response router sharing the node coordinate.
 */

`timescale 1ns/10ps

module noc_nw_router (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  noc_pkg::noc_coord_t                        id_i,
  // Request network
  input  noc_pkg::noc_port_vec_t                     req_valid_i,
  output noc_pkg::noc_port_vec_t                     req_ready_o,
  input  noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] req_flit_i,
  output noc_pkg::noc_port_vec_t                     req_valid_o,
  input  noc_pkg::noc_port_vec_t                     req_ready_i,
  output noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] req_flit_o,
  // Response network
  input  noc_pkg::noc_port_vec_t                     rsp_valid_i,
  output noc_pkg::noc_port_vec_t                     rsp_ready_o,
  input  noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] rsp_flit_i,
  output noc_pkg::noc_port_vec_t                     rsp_valid_o,
  input  noc_pkg::noc_port_vec_t                     rsp_ready_i,
  output noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] rsp_flit_o
);

  noc_router i_req_router (
    .clk_i,
    .rst_n_i,
    .id_i,
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .flit_i  ( req_flit_i  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i ),
    .flit_o  ( req_flit_o  )
  );

  noc_router i_rsp_router (
    .clk_i,
    .rst_n_i,
    .id_i,
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .flit_i  ( rsp_flit_i  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .flit_o  ( rsp_flit_o  )
  );

endmodule

//--- hw/noc_out_port.sv
/*
 * NoC router output port
 * One-entry register that holds a switched flit until the
 * neighbor accepts it over the valid/ready link.
 */

`timescale 1ns/10ps

module noc_out_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               load_i,
  input  noc_pkg::noc_flit_t flit_i,
  output logic               free_o,
  output logic               valid_o,
  output noc_pkg::noc_flit_t flit_o,
  input  logic               ready_i
);

  import noc_pkg::*;

  logic      full_q;
  noc_flit_t flit_q;

  // Room for a new flit if empty or draining this cycle
  assign free_o  = !full_q || ready_i;
  assign valid_o = full_q;
  assign flit_o  = flit_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load_i) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      flit_q <= flit_i;
    end
  end

  // A stalled flit stays put on the link
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(flit_o)))
    else $error("output flit changed while stalled");

  // The allocator must respect free_o
  assert property (@(posedge clk_i) disable iff (!rst_n_i) load_i |-> free_o)
    else $error("output loaded while occupied");

endmodule

//--- hw/noc_pkg.sv
/*
 * Mesh NoC router shared definitions
 * Node coordinates, flit layout, port directions and buffer sizing
 * used by the request and response routers.
 */

package noc_pkg;

  // Local port plus the four mesh neighbors
  localparam int unsigned NumPorts = 5;

  // Flits held by each input FIFO
  localparam int unsigned InFifoDepth = 2;

  // FIFO pointer and fill counter widths
  localparam int unsigned FifoPtrW = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned FifoCntW = $clog2(InFifoDepth + 1);

  // Node position inside a 4x4 mesh
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } noc_coord_t;

  // One flit on either network
  typedef struct packed {
    noc_coord_t  dst;
    noc_coord_t  src;
    logic [15:0] payload;
  } noc_flit_t;

  // Port index and routing direction
  // North is y+1, East is x+1, South is y-1, West is x-1
  typedef enum logic [2:0] {
    DirLocal = 3'd0,
    DirNorth = 3'd1,
    DirEast  = 3'd2,
    DirSouth = 3'd3,
    DirWest  = 3'd4
  } noc_dir_e;

  // One bit per port for valid, ready, request and grant vectors
  typedef logic [NumPorts-1:0] noc_port_vec_t;

endpackage

//--- hw/noc_router.sv
/*
 * Five-port XY mesh router
 * Input FIFOs, round-robin switch allocation, crossbar and
 * registered valid/ready outputs.
 */

`timescale 1ns/10ps

module noc_router (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  noc_pkg::noc_coord_t                        id_i,
  input  noc_pkg::noc_port_vec_t                     valid_i,
  output noc_pkg::noc_port_vec_t                     ready_o,
  input  noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] flit_i,
  output noc_pkg::noc_port_vec_t                     valid_o,
  input  noc_pkg::noc_port_vec_t                     ready_i,
  output noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] flit_o
);

  import noc_pkg::*;

  noc_port_vec_t                head_valid;
  noc_flit_t     [NumPorts-1:0] head_flit;
  noc_dir_e      [NumPorts-1:0] route;
  noc_port_vec_t [NumPorts-1:0] grant;
  noc_port_vec_t                pop;
  noc_port_vec_t                out_free;
  noc_port_vec_t                load;
  noc_flit_t     [NumPorts-1:0] xbar_flit;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in_port
    noc_in_port #(
      .in_dir ( noc_dir_e'(i) )
    ) i_in_port (
      .clk_i,
      .rst_n_i,
      .id_i,
      .valid_i      ( valid_i[i]    ),
      .flit_i       ( flit_i[i]     ),
      .ready_o      ( ready_o[i]    ),
      .pop_i        ( pop[i]        ),
      .head_valid_o ( head_valid[i] ),
      .head_flit_o  ( head_flit[i]  ),
      .route_o      ( route[i]      )
    );
  end

  noc_sw_alloc i_sw_alloc (
    .clk_i,
    .rst_n_i,
    .req_valid_i ( head_valid ),
    .req_dir_i   ( route      ),
    .out_ready_i ( out_free   ),
    .grant_o     ( grant      ),
    .pop_o       ( pop        )
  );

  // Crossbar as an AND-OR mux over the one-hot grants
  always_comb begin
    for (int unsigned o = 0; o < NumPorts; o++) begin
      xbar_flit[o] = '0;
      for (int unsigned i = 0; i < NumPorts; i++) begin
        xbar_flit[o] = xbar_flit[o] | (head_flit[i] & {$bits(noc_flit_t){grant[o][i]}});
      end
      load[o] = |grant[o];
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out_port
    noc_out_port i_out_port (
      .clk_i,
      .rst_n_i,
      .load_i  ( load[o]      ),
      .flit_i  ( xbar_flit[o] ),
      .free_o  ( out_free[o]  ),
      .valid_o ( valid_o[o]   ),
      .flit_o  ( flit_o[o]    ),
      .ready_i ( ready_i[o]   )
    );
  end

endmodule

//--- hw/noc_sw_alloc.sv
/*
 * NoC switch allocator
 * Per output, grants one requesting input by round-robin when the
 * output register can take a flit, and pops the winning inputs.
 */

`timescale 1ns/10ps

module noc_sw_alloc (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  noc_pkg::noc_port_vec_t                        req_valid_i,
  input  noc_pkg::noc_dir_e [noc_pkg::NumPorts-1:0]     req_dir_i,
  input  noc_pkg::noc_port_vec_t                        out_ready_i,
  output noc_pkg::noc_port_vec_t [noc_pkg::NumPorts-1:0] grant_o,
  output noc_pkg::noc_port_vec_t                        pop_o
);

  import noc_pkg::*;

  // req_mat[o][i] is set when input i wants output o
  noc_port_vec_t [NumPorts-1:0] req_mat;
  // gnt_col[i][o] is the transpose of the grants
  noc_port_vec_t [NumPorts-1:0] gnt_col;
  // Highest priority input per output
  noc_dir_e [NumPorts-1:0] ptr_q;
  noc_dir_e [NumPorts-1:0] ptr_d;

  always_comb begin
    for (int unsigned o = 0; o < NumPorts; o++) begin
      for (int unsigned i = 0; i < NumPorts; i++) begin
        req_mat[o][i] = req_valid_i[i] && (req_dir_i[i] == noc_dir_e'(o));
      end
    end
  end

  // Search starts at the pointer and wraps around
  always_comb begin
    int unsigned idx;
    logic        found;
    grant_o = '0;
    ptr_d   = ptr_q;
    for (int unsigned o = 0; o < NumPorts; o++) begin
      found = 1'b0;
      for (int unsigned k = 0; k < NumPorts; k++) begin
        idx = int'(ptr_q[o]) + k;
        if (idx >= NumPorts) begin
          idx = idx - NumPorts;
        end
        if (!found && out_ready_i[o] && req_mat[o][idx]) begin
          found          = 1'b1;
          grant_o[o][idx] = 1'b1;
          ptr_d[o]       = (idx == NumPorts - 1) ? DirLocal : noc_dir_e'(idx + 1);
        end
      end
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      for (int unsigned o = 0; o < NumPorts; o++) begin
        gnt_col[i][o] = grant_o[o][i];
      end
      pop_o[i] = |gnt_col[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= {NumPorts{DirLocal}};
    end else begin
      ptr_q <= ptr_d;
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_chk
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(grant_o[p]))
      else $error("output %0d granted to several inputs", p);
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_col[p]))
      else $error("input %0d granted by several outputs", p);
  end

endmodule

//--- sim.f
hw/noc_pkg.sv
hw/noc_in_port.sv
hw/noc_sw_alloc.sv
hw/noc_out_port.sv
hw/noc_router.sv
hw/noc_nw_router.sv
testbench/tb_noc_nw_router.sv

//--- testbench/tb_noc_nw_router.sv
/*
 * Testbench for the two-network router node
 * Sends directed, flooding and random flits into the request and response
 * routers and matches every output transfer against an XY routing model.
 */

`timescale 1ns/10ps

module tb_noc_nw_router;

  import noc_pkg::*;

  localparam int NumFlits  = 400;
  localparam int RstCycles = 10;
  localparam int MaxCycles = NumFlits * 10 + RstCycles;
  // Flits per flooding input and network
  localparam int FloodCnt  = 20;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  noc_coord_t               id_i;
  // Index 0 is the request network, 1 the response network
  noc_port_vec_t            valid_i [2];
  noc_port_vec_t            ready_o [2];
  noc_flit_t [NumPorts-1:0] flit_i  [2];
  noc_port_vec_t            valid_o [2];
  noc_port_vec_t            ready_i [2];
  noc_flit_t [NumPorts-1:0] flit_o  [2];

  // Expected flits per network, input and output
  noc_flit_t     exp_q [2][NumPorts][NumPorts][$];
  logic [12:0]   seq [2][NumPorts];
  noc_port_vec_t send_en;
  logic          use_fixed;
  noc_coord_t    fixed_dst;
  logic          rand_rdy;
  logic          flood;
  int            sent;
  int            budget;
  int            cycles;
  int            flood_cnt [2];
  int            last_in [2];
  integer        seed = 32'hbaee09f2;

  noc_nw_router noc_nw_router_inst (
    .clk_i,
    .rst_n_i,
    .id_i,
    .req_valid_i ( valid_i[0] ),
    .req_ready_o ( ready_o[0] ),
    .req_flit_i  ( flit_i[0]  ),
    .req_valid_o ( valid_o[0] ),
    .req_ready_i ( ready_i[0] ),
    .req_flit_o  ( flit_o[0]  ),
    .rsp_valid_i ( valid_i[1] ),
    .rsp_ready_o ( ready_o[1] ),
    .rsp_flit_i  ( flit_i[1]  ),
    .rsp_valid_o ( valid_o[1] ),
    .rsp_ready_i ( ready_i[1] ),
    .rsp_flit_o  ( flit_o[1]  )
  );

  always #50 clk_i = ~clk_i;

  // Reference XY route that resolves x before y
  function automatic noc_dir_e xy_route(noc_coord_t dst);
    if (dst.x != id_i.x) begin
      return (dst.x > id_i.x) ? DirEast : DirWest;
    end else if (dst.y != id_i.y) begin
      return (dst.y > id_i.y) ? DirNorth : DirSouth;
    end
    return DirLocal;
  endfunction

  // Random destinations never turn back through the input port
  function automatic noc_flit_t make_flit(int n, int p);
    noc_flit_t f;
    f.dst = fixed_dst;
    if (!use_fixed) begin
      do begin
        f.dst = 4'($random(seed));
      end while (xy_route(f.dst) == noc_dir_e'(p));
    end
    f.src     = '{x: 2'(n), y: 2'd0};
    f.payload = {3'(p), seq[n][p]};
    return f;
  endfunction

  function automatic bit queues_empty();
    for (int n = 0; n < 2; n++) begin
      for (int i = 0; i < NumPorts; i++) begin
        for (int o = 0; o < NumPorts; o++) begin
          if (exp_q[n][i][o].size() != 0) begin
            return 1'b0;
          end
        end
      end
    end
    return 1'b1;
  endfunction

  task automatic report_failure(string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_flit(string name, noc_flit_t exp, noc_flit_t got);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_dir(string name, noc_dir_e exp, noc_dir_e got);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  // Enables the given inputs until count more flits have been delivered
  task automatic run_phase(noc_port_vec_t mask, int count);
    send_en = mask;
    budget  = sent + count;
    while (sent != budget || !queues_empty()) begin
      @(negedge clk_i);
    end
    send_en = '0;
  endtask

  // One flit per network from an input that cannot loop back
  task automatic send_single(noc_coord_t dst);
    fixed_dst = dst;
    use_fixed = 1'b1;
    run_phase((xy_route(dst) == DirLocal) ? 5'b00010 : 5'b00001, 2);
    use_fixed = 1'b0;
  endtask

  // Each flit stays valid until the DUT takes it
  always @(posedge clk_i) begin
    noc_port_vec_t flip;
    noc_flit_t     f;
    for (int n = 0; n < 2; n++) begin
      flip = noc_port_vec_t'($random(seed) & $random(seed));
      ready_i[n] <= rand_rdy ? (ready_i[n] ^ flip) : '1;
      for (int p = 0; p < NumPorts; p++) begin
        if (rst_n_i && (!valid_i[n][p] || ready_o[n][p])) begin
          if (send_en[p] && sent < budget) begin
            f = make_flit(n, p);
            exp_q[n][p][xy_route(f.dst)].push_back(f);
            seq[n][p] = seq[n][p] + 1'b1;
            sent = sent + 1;
            flit_i[n][p]  <= f;
            valid_i[n][p] <= 1'b1;
          end else begin
            valid_i[n][p] <= 1'b0;
          end
        end
      end
    end
  end

  // The payload names the input queue to match against
  always @(posedge clk_i) begin
    noc_flit_t got;
    int        src_in;
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      report_failure("timeout, some expected flits never arrived");
    end
    for (int n = 0; n < 2; n++) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (rst_n_i && valid_o[n][o] && ready_i[n][o]) begin
          got    = flit_o[n][o];
          src_in = got.payload[15:13];
          check_dir($sformatf("%s output port", n ? "rsp" : "req"),
                    xy_route(got.dst), noc_dir_e'(o));
          if (src_in >= NumPorts || exp_q[n][src_in][o].size() == 0) begin
            report_failure($sformatf("unexpected flit %h on output %0d", got, o));
          end
          check_flit($sformatf("%s_flit_o[%0d]", n ? "rsp" : "req", o),
                     exp_q[n][src_in][o].pop_front(), got);
          // Both flooding inputs stay backlogged through this window
          if (flood && o == DirLocal) begin
            if (flood_cnt[n] > 0 && flood_cnt[n] < 2 * FloodCnt - 10 &&
                src_in == last_in[n]) begin
              report_failure("round-robin gave one input two Local transfers in a row");
            end
            flood_cnt[n] = flood_cnt[n] + 1;
            last_in[n]   = src_in;
          end
        end
      end
    end
  end

  initial begin
    rst_n_i   = 1'b0;
    id_i      = '{x: 2'd1, y: 2'd1};
    valid_i   = '{default: '0};
    flit_i    = '{default: '0};
    ready_i   = '{default: '1};
    seq       = '{default: '0};
    send_en   = '0;
    use_fixed = 1'b0;
    fixed_dst = '0;
    rand_rdy  = 1'b0;
    flood     = 1'b0;
    sent      = 0;
    budget    = 0;
    cycles    = 0;
    flood_cnt = '{0, 0};
    last_in   = '{0, 0};
    repeat (RstCycles) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Nothing sent yet, so no output is valid and every input has room
    repeat (5) begin
      @(negedge clk_i);
      if (valid_o[0] !== '0 || valid_o[1] !== '0) begin
        report_failure("output valid raised after reset with no traffic");
      end
      if (ready_o[0] !== '1 || ready_o[1] !== '1) begin
        report_failure("input ready low after reset with empty FIFOs");
      end
    end
    send_single('{x: 2'd1, y: 2'd1});
    send_single('{x: 2'd3, y: 2'd1});
    send_single('{x: 2'd1, y: 2'd3});
    send_single('{x: 2'd1, y: 2'd0});
    send_single('{x: 2'd0, y: 2'd2});
    // East and West inputs both flood the Local output
    flood     = 1'b1;
    use_fixed = 1'b1;
    fixed_dst = id_i;
    run_phase(5'b10100, 4 * FloodCnt);
    flood     = 1'b0;
    use_fixed = 1'b0;
    run_phase('1, (NumFlits - sent) / 2);
    rand_rdy = 1'b1;
    run_phase('1, NumFlits - sent);
    $display("TEST PASS");
    $finish;
  end

endmodule
